/* Bender.yml */
package:
  name: asg

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/asg_pkg.sv
      - logic/asg_regs.sv
      - logic/asg_seq.sv
      - logic/asg_table.sv
      - logic/asg_out.sv
      - logic/asg_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/asg_props.sv
      - tb/asg_tb.sv

/* logic/asg_out.sv */
// two-entry skid stage in front of the output stream
// upstream moves a sample in only while stall is low
// stall is high exactly while both entries hold data

`default_nettype none

module asg_out import asg_pkg::*; (
  input  logic    sto,
  input  logic    ctl_rst,
  // from the table read stage
  input  logic    smp_valid,
  input  sample_t smp_data,
  input  logic    smp_last,
  // stream out
  output sample_t out_tdata,
  output logic    out_tvalid,
  output logic    out_tlast,
  input  logic    out_tready,
  output logic    stall
);

  // entry 0 drives the stream, entry 1 is the skid slot
  logic    vld0;
  logic    vld1;
  sample_t dat0;
  sample_t dat1;
  logic    lst0;
  logic    lst1;
  logic    push;
  logic    pop;

  assign stall      = vld0 & vld1;
  assign push       = smp_valid & ~stall;
  assign pop        = vld0 & out_tready;
  assign out_tvalid = vld0;
  assign out_tdata  = dat0;
  assign out_tlast  = vld0 & lst0;

  // occupancy
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      vld0 <= 1'b0;
      vld1 <= 1'b0;
    end else if (pop) begin
      vld0 <= vld1 | push;
      vld1 <= vld1 & push;
    end else begin
      vld0 <= vld0 | push;
      vld1 <= vld1 | (vld0 & push);
    end
  end

  // payload
  always_ff @(posedge sto) begin
    // head refills from skid slot first
    if (pop && vld1) begin
      dat0 <= dat1;
      lst0 <= lst1;
    end else if (pop || !vld0) begin
      dat0 <= smp_data;
      lst0 <= smp_last;
    end
    // skid slot catches the sample behind the head
    if (push && (pop ? vld1 : vld0)) begin
      dat1 <= smp_data;
      lst1 <= smp_last;
    end
  end

endmodule

`default_nettype wire

/* logic/asg_params.svh */
// sizing macros for one generator channel
// the table must span 2**ASG_AW entries of the 0x400 register window
// ASG_REG_AW must leave bits 11:10 free for the table region decode
// phase pointer width is ASG_AW + ASG_FW and must stay at 16 bits or less

`ifndef ASG_PARAMS_SVH
`define ASG_PARAMS_SVH

//////////////////////////////////////////////////
// table and pointer
//////////////////////////////////////////////////

// table address bits, 256 entries
`define ASG_AW 8
// pointer fraction bits
`define ASG_FW 8

//////////////////////////////////////////////////
// data and bus
//////////////////////////////////////////////////

// DAC sample width
`define ASG_DW 14
// AXI4-Lite byte address bits
`define ASG_REG_AW 12

`endif

/* logic/asg_pkg.sv */
// shared types for the generator channel
// widths follow the macros in asg_params.svh
// phase_t is unsigned fixed point, integer part on top

`default_nettype none

`include "asg_params.svh"

package asg_pkg;

  // one output sample
  typedef logic [`ASG_DW-1:0] sample_t;

  // table index
  typedef logic [`ASG_AW-1:0] tab_addr_t;

  // integer part ASG_AW bits, fraction ASG_FW bits
  typedef logic [`ASG_AW+`ASG_FW-1:0] phase_t;

  // burst period counter and repeat counter
  typedef logic [31:0] cnt_t;
  typedef logic [15:0] rep_t;

  // host byte address
  typedef logic [`ASG_REG_AW-1:0] reg_addr_t;

  // sequencer states
  typedef enum logic [1:0] {IDLE, DATA, HOLD, DONE} seq_state_t;

endpackage

`default_nettype wire

/* logic/asg_regs.sv */
// AXI4-Lite slave for channel settings and table access
// one write and one read outstanding at a time, bresp/rresp always OKAY
// low two address bits are ignored, accesses are treated as word wide
// table reads take one cycle more than register reads
// a table read is held off while a table write is accepted in the same cycle

`default_nettype none

`include "asg_params.svh"

module asg_regs import asg_pkg::*; (
  input  logic      sto,
  input  logic      ctl_rst,
  // AXI4-Lite
  input  reg_addr_t axil_awaddr,
  input  logic      axil_awvalid,
  output logic      axil_awready,
  input  logic [31:0] axil_wdata,
  input  logic [3:0]  axil_wstrb,
  input  logic      axil_wvalid,
  output logic      axil_wready,
  output logic [1:0]  axil_bresp,
  output logic      axil_bvalid,
  input  logic      axil_bready,
  input  reg_addr_t axil_araddr,
  input  logic      axil_arvalid,
  output logic      axil_arready,
  output logic [31:0] axil_rdata,
  output logic [1:0]  axil_rresp,
  output logic      axil_rvalid,
  input  logic      axil_rready,
  // settings
  input  logic      running,
  output logic      run_en,
  output logic      sw_trg,
  output logic      burst_en,
  output logic      infinite,
  output logic      ext_trg_en,
  output phase_t    cfg_siz,
  output phase_t    cfg_stp,
  output phase_t    cfg_off,
  output cnt_t      cfg_bdl,
  output cnt_t      cfg_bln,
  output rep_t      cfg_bnm,
  // table host port
  output logic      tab_we,
  output logic      tab_ren,
  output tab_addr_t tab_addr,
  output sample_t   tab_wdata,
  input  sample_t   tab_rdata
);

  localparam reg_addr_t ADDR_CTRL   = 'h000;
  localparam reg_addr_t ADDR_SIZ    = 'h004;
  localparam reg_addr_t ADDR_STP    = 'h008;
  localparam reg_addr_t ADDR_OFF    = 'h00C;
  localparam reg_addr_t ADDR_BDL    = 'h010;
  localparam reg_addr_t ADDR_BLN    = 'h014;
  localparam reg_addr_t ADDR_BNM    = 'h018;
  localparam reg_addr_t ADDR_STATUS = 'h01C;
  localparam reg_addr_t TAB_BASE    = 'h400;

  reg_addr_t   aw_word;
  reg_addr_t   ar_word;
  logic        aw_tab;
  logic        ar_tab;
  logic        wr_acc;
  logic        rd_acc;
  logic        tab_pend;
  logic [31:0] reg_rdata;

  // merge write data into a register under the byte strobes
  function automatic logic [31:0] strb_merge(input logic [31:0] cur,
                                             input logic [31:0] dat,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = dat[8*i +: 8];
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // address decode and handshakes
  //////////////////////////////////////////////////

  assign aw_word = {axil_awaddr[`ASG_REG_AW-1:2], 2'b00};
  assign ar_word = {axil_araddr[`ASG_REG_AW-1:2], 2'b00};
  assign aw_tab  = aw_word[`ASG_REG_AW-1:10] == TAB_BASE[`ASG_REG_AW-1:10];
  assign ar_tab  = ar_word[`ASG_REG_AW-1:10] == TAB_BASE[`ASG_REG_AW-1:10];

  // write needs both channels and a free response slot
  assign wr_acc       = axil_awvalid & axil_wvalid & ~axil_bvalid;
  assign axil_awready = wr_acc;
  assign axil_wready  = wr_acc;
  assign axil_bresp   = 2'b00;

  // read blocked while data pending or table port taken by a write
  assign rd_acc       = axil_arvalid & ~axil_rvalid & ~tab_pend & ~(ar_tab & tab_we);
  assign axil_arready = rd_acc;
  assign axil_rresp   = 2'b00;

  // table host port, write has priority on the shared address
  assign tab_we    = wr_acc & aw_tab;
  assign tab_ren   = rd_acc & ar_tab;
  assign tab_addr  = tab_we ? aw_word[2 +: $bits(tab_addr_t)] : ar_word[2 +: $bits(tab_addr_t)];
  assign tab_wdata = axil_wdata[$bits(sample_t)-1:0];

  //////////////////////////////////////////////////
  // settings registers
  //////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      run_en     <= 1'b0;
      sw_trg     <= 1'b0;
      burst_en   <= 1'b0;
      infinite   <= 1'b0;
      ext_trg_en <= 1'b0;
      cfg_siz    <= '0;
      cfg_stp    <= '0;
      cfg_off    <= '0;
      cfg_bdl    <= '0;
      cfg_bln    <= '0;
      cfg_bnm    <= '0;
    end else begin
      // software trigger is a one cycle pulse
      sw_trg <= 1'b0;
      if (wr_acc) begin
        case (aw_word)
          ADDR_CTRL: begin
            if (axil_wstrb[0]) begin
              run_en     <= axil_wdata[0];
              sw_trg     <= axil_wdata[1];
              burst_en   <= axil_wdata[2];
              infinite   <= axil_wdata[3];
              ext_trg_en <= axil_wdata[4];
            end
          end
          ADDR_SIZ: cfg_siz <= phase_t'(strb_merge(32'(cfg_siz), axil_wdata, axil_wstrb));
          ADDR_STP: cfg_stp <= phase_t'(strb_merge(32'(cfg_stp), axil_wdata, axil_wstrb));
          ADDR_OFF: cfg_off <= phase_t'(strb_merge(32'(cfg_off), axil_wdata, axil_wstrb));
          ADDR_BDL: cfg_bdl <= strb_merge(cfg_bdl, axil_wdata, axil_wstrb);
          ADDR_BLN: cfg_bln <= strb_merge(cfg_bln, axil_wdata, axil_wstrb);
          ADDR_BNM: cfg_bnm <= rep_t'(strb_merge(32'(cfg_bnm), axil_wdata, axil_wstrb));
          // status, table and holes
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////

  always_comb begin
    case (ar_word)
      ADDR_CTRL:   reg_rdata = {27'd0, ext_trg_en, infinite, burst_en, 1'b0, run_en};
      ADDR_SIZ:    reg_rdata = 32'(cfg_siz);
      ADDR_STP:    reg_rdata = 32'(cfg_stp);
      ADDR_OFF:    reg_rdata = 32'(cfg_off);
      ADDR_BDL:    reg_rdata = cfg_bdl;
      ADDR_BLN:    reg_rdata = cfg_bln;
      ADDR_BNM:    reg_rdata = 32'(cfg_bnm);
      ADDR_STATUS: reg_rdata = {31'd0, running};
      default:     reg_rdata = '0;
    endcase
  end

  // response flags
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      axil_bvalid <= 1'b0;
      axil_rvalid <= 1'b0;
      tab_pend    <= 1'b0;
    end else begin
      if (wr_acc) axil_bvalid <= 1'b1;
      else if (axil_bready) axil_bvalid <= 1'b0;
      // table data lands one cycle after the RAM read
      tab_pend <= tab_ren;
      if ((rd_acc & ~ar_tab) | tab_pend) axil_rvalid <= 1'b1;
      else if (axil_rready) axil_rvalid <= 1'b0;
    end
  end

  // read data, zero extended table sample
  always_ff @(posedge sto) begin
    if (rd_acc & ~ar_tab) axil_rdata <= reg_rdata;
    else if (tab_pend) axil_rdata <= 32'(tab_rdata);
  end

endmodule

`default_nettype wire

/* logic/asg_seq.sv */
// playback sequencer, issues one table read or hold per unstalled cycle
// triggers are level qualified and ignored unless the channel is idle
// a finite burst parks in DONE, still running, until run enable is cleared
// each burst period restarts the pointer from the offset
// periodic mode never flags the last sample

`default_nettype none

`include "asg_params.svh"

module asg_seq import asg_pkg::*; (
  input  logic      sto,
  input  logic      ctl_rst,
  input  logic      trg,
  // settings
  input  logic      run_en,
  input  logic      sw_trg,
  input  logic      burst_en,
  input  logic      infinite,
  input  logic      ext_trg_en,
  input  phase_t    cfg_siz,
  input  phase_t    cfg_stp,
  input  phase_t    cfg_off,
  input  cnt_t      cfg_bdl,
  input  cnt_t      cfg_bln,
  input  rep_t      cfg_bnm,
  // back-pressure from the output stage
  input  logic      stall,
  // table read issue
  output logic      rd_en,
  output logic      rd_hold,
  output tab_addr_t rd_addr,
  output logic      rd_last,
  output logic      running
);

  // two spare bits for carry and sign
  localparam int PW = `ASG_AW + `ASG_FW;

  seq_state_t    state;
  phase_t        ptr;
  logic [PW+1:0] ptr_sum;
  logic [PW+1:0] ptr_sub;
  phase_t        ptr_nxt;
  cnt_t          cnt_bln;
  rep_t          cnt_bnm;
  logic          trg_q;
  logic          issue;
  logic          end_bdl;
  logic          end_bln;
  logic          end_bnm;

  //////////////////////////////////////////////////
  // trigger and issue
  //////////////////////////////////////////////////

  assign trg_q = sw_trg | (ext_trg_en & trg);

  // one sample per cycle unless stalled
  assign issue   = run_en & ~stall & ((state == DATA) | (state == HOLD));
  assign rd_en   = issue & (state == DATA);
  assign rd_hold = issue & (state == HOLD);
  assign rd_addr = ptr[`ASG_FW +: `ASG_AW];
  assign running = state != IDLE;

  // counter end flags
  assign end_bdl = cnt_bln == cfg_bdl;
  assign end_bln = cnt_bln == cfg_bln;
  assign end_bnm = cnt_bnm == cfg_bnm;

  // final sample of a finite burst
  assign rd_last = issue & burst_en & ~infinite & end_bln & end_bnm;

  //////////////////////////////////////////////////
  // pointer with modulo wrap
  //////////////////////////////////////////////////

  // step and size are stored minus one
  assign ptr_sum = {2'b00, ptr} + {2'b00, cfg_stp} + (PW+2)'(1);
  assign ptr_sub = ptr_sum - ({2'b00, cfg_siz} + (PW+2)'(1));
  // take the wrapped value unless it went negative
  assign ptr_nxt = ptr_sub[PW+1] ? ptr_sum[PW-1:0] : ptr_sub[PW-1:0];

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state   <= IDLE;
      ptr     <= '0;
      cnt_bln <= '0;
      cnt_bnm <= '0;
    end else if (!run_en) begin
      // disable stops playback from any state
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (trg_q) begin
            state   <= DATA;
            ptr     <= cfg_off;
            cnt_bln <= '0;
            cnt_bnm <= '0;
          end
        end
        DATA, HOLD: begin
          if (!stall) begin
            // pointer only moves on real reads
            if (state == DATA) ptr <= ptr_nxt;
            if (burst_en) begin
              if (end_bln) begin
                // period done, rewind
                cnt_bln <= '0;
                ptr     <= cfg_off;
                if (end_bnm && !infinite) begin
                  state <= DONE;
                end else begin
                  state <= DATA;
                  if (!infinite) cnt_bnm <= cnt_bnm + 1'b1;
                end
              end else begin
                cnt_bln <= cnt_bln + 1'b1;
                // data part over, repeat last value
                if (state == DATA && end_bdl) state <= HOLD;
              end
            end
          end
        end
        // DONE waits for run enable to drop
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/asg_table.sv */
// waveform RAM, host port plus playback read port
// host reads return one cycle after tab_ren
// playback register has no reset of its own, so ctl_rst must be held
// for at least two cycles to flush smp_valid

`default_nettype none

`include "asg_params.svh"

module asg_table import asg_pkg::*; (
  input  logic      sto,
  // host port
  input  logic      tab_we,
  input  logic      tab_ren,
  input  tab_addr_t tab_addr,
  input  sample_t   tab_wdata,
  output sample_t   tab_rdata,
  // playback port
  input  logic      rd_en,
  input  logic      rd_hold,
  input  tab_addr_t rd_addr,
  input  logic      rd_last,
  input  logic      stall,
  output logic      smp_valid,
  output sample_t   smp_data,
  output logic      smp_last
);

  sample_t mem [0:2**`ASG_AW-1];

  // host write and readback
  always_ff @(posedge sto) begin
    if (tab_we) mem[tab_addr] <= tab_wdata;
    if (tab_ren) tab_rdata <= mem[tab_addr];
  end

  // playback register frozen while the output stage is full
  always_ff @(posedge sto) begin
    if (!stall) begin
      smp_valid <= rd_en | rd_hold;
      smp_last  <= rd_last;
      // hold keeps the previous sample
      if (rd_en) smp_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* logic/asg_top.sv */
// one generator channel, AXI4-Lite settings and a sample stream out
// single clock sto, synchronous active high ctl_rst
// trg is expected synchronous to sto

`default_nettype none

`include "asg_params.svh"

module asg_top import asg_pkg::*; (
  input  logic                   sto,
  input  logic                   ctl_rst,
  input  logic                   trg,
  // AXI4-Lite
  input  logic [`ASG_REG_AW-1:0] axil_awaddr,
  input  logic                   axil_awvalid,
  output logic                   axil_awready,
  input  logic [31:0]            axil_wdata,
  input  logic [3:0]             axil_wstrb,
  input  logic                   axil_wvalid,
  output logic                   axil_wready,
  output logic [1:0]             axil_bresp,
  output logic                   axil_bvalid,
  input  logic                   axil_bready,
  input  logic [`ASG_REG_AW-1:0] axil_araddr,
  input  logic                   axil_arvalid,
  output logic                   axil_arready,
  output logic [31:0]            axil_rdata,
  output logic [1:0]             axil_rresp,
  output logic                   axil_rvalid,
  input  logic                   axil_rready,
  // stream out
  output sample_t                out_tdata,
  output logic                   out_tvalid,
  output logic                   out_tlast,
  input  logic                   out_tready
);

  // settings
  logic      run_en, sw_trg, burst_en, infinite, ext_trg_en;
  phase_t    cfg_siz, cfg_stp, cfg_off;
  cnt_t      cfg_bdl, cfg_bln;
  rep_t      cfg_bnm;
  logic      running;
  // table host port
  logic      tab_we, tab_ren;
  tab_addr_t tab_addr;
  sample_t   tab_wdata, tab_rdata;
  // playback path
  logic      rd_en, rd_hold, rd_last;
  tab_addr_t rd_addr;
  logic      smp_valid, smp_last;
  sample_t   smp_data;
  logic      stall;

  asg_regs u_regs (
    .sto, .ctl_rst,
    .axil_awaddr, .axil_awvalid, .axil_awready,
    .axil_wdata, .axil_wstrb, .axil_wvalid, .axil_wready,
    .axil_bresp, .axil_bvalid, .axil_bready,
    .axil_araddr, .axil_arvalid, .axil_arready,
    .axil_rdata, .axil_rresp, .axil_rvalid, .axil_rready,
    .running, .run_en, .sw_trg, .burst_en, .infinite, .ext_trg_en,
    .cfg_siz, .cfg_stp, .cfg_off, .cfg_bdl, .cfg_bln, .cfg_bnm,
    .tab_we, .tab_ren, .tab_addr, .tab_wdata, .tab_rdata
  );

  // producer
  asg_seq u_seq (
    .sto, .ctl_rst, .trg,
    .run_en, .sw_trg, .burst_en, .infinite, .ext_trg_en,
    .cfg_siz, .cfg_stp, .cfg_off, .cfg_bdl, .cfg_bln, .cfg_bnm,
    .stall, .rd_en, .rd_hold, .rd_addr, .rd_last, .running
  );

  // buffer
  asg_table u_table (
    .sto, .tab_we, .tab_ren, .tab_addr, .tab_wdata, .tab_rdata,
    .rd_en, .rd_hold, .rd_addr, .rd_last, .stall,
    .smp_valid, .smp_data, .smp_last
  );

  // consumer
  asg_out u_out (
    .sto, .ctl_rst, .smp_valid, .smp_data, .smp_last,
    .out_tdata, .out_tvalid, .out_tlast, .out_tready, .stall
  );

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/asg_pkg.sv
logic/asg_regs.sv
logic/asg_seq.sv
logic/asg_table.sv
logic/asg_out.sv
logic/asg_top.sv
tb/asg_props.sv
tb/asg_tb.sv

/* tb/asg_props.sv */
// concurrent checks on the stream, the skid stage and the bus responses
// bound into the channel top, where stall and running are visible
// fail_cnt tallies assertion failures

`default_nettype none

module asg_props import asg_pkg::*; (
  input logic    sto,
  input logic    ctl_rst,
  input sample_t out_tdata,
  input logic    out_tvalid,
  input logic    out_tlast,
  input logic    out_tready,
  input logic    stall,
  input logic    running,
  input logic    axil_bvalid,
  input logic    axil_bready,
  input logic    axil_rvalid,
  input logic    axil_rready
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  // payload frozen while the sink stalls
  a_stable: assert property (@(posedge sto) disable iff (ctl_rst)
    out_tvalid && !out_tready |=> $stable(out_tdata) && $stable(out_tlast))
    else begin
      fail_cnt++;
      $error("stream payload changed under back-pressure");
    end

  // drain takes at most 3 cycles once the sequencer is idle
  a_idle: assert property (@(posedge sto) disable iff (ctl_rst)
    !running && !$past(running) && !$past(running, 2) && !$past(running, 3) |-> !out_tvalid)
    else begin
      fail_cnt++;
      $error("out_tvalid with the sequencer idle");
    end

  // responses held until taken
  a_bhold: assert property (@(posedge sto) disable iff (ctl_rst)
    axil_bvalid && !axil_bready |=> axil_bvalid)
    else begin
      fail_cnt++;
      $error("bvalid dropped before bready");
    end

  a_rhold: assert property (@(posedge sto) disable iff (ctl_rst)
    axil_rvalid && !axil_rready |=> axil_rvalid)
    else begin
      fail_cnt++;
      $error("rvalid dropped before rready");
    end

  a_rst: assert property (@(posedge sto) ctl_rst |=> !stall)
    else begin
      fail_cnt++;
      $error("stall high right after reset");
    end

endmodule

`default_nettype wire

/* tb/asg_tb.sv */
// directed testbench for one generator channel
// table contents and back-pressure come from a 17-bit LFSR
// expects the AXI4-Lite slave to hold one transfer in flight at a time
// bready and rready rise one cycle after each response appears
// the run ends on a cycle limit if the DUT stops responding

`default_nettype none

`include "asg_params.svh"

module asg_tb import asg_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TAB_N = 2**`ASG_AW;
  localparam reg_addr_t ADDR_CTRL   = 'h000;
  localparam reg_addr_t ADDR_SIZ    = 'h004;
  localparam reg_addr_t ADDR_STP    = 'h008;
  localparam reg_addr_t ADDR_OFF    = 'h00C;
  localparam reg_addr_t ADDR_BDL    = 'h010;
  localparam reg_addr_t ADDR_BLN    = 'h014;
  localparam reg_addr_t ADDR_BNM    = 'h018;
  localparam reg_addr_t ADDR_STATUS = 'h01C;
  localparam int TAB_BASE = 'h400;
  // ctrl bits
  localparam logic [31:0] C_RUN = 32'h01;
  localparam logic [31:0] C_SWT = 32'h02;
  localparam logic [31:0] C_BST = 32'h04;
  localparam logic [31:0] C_EXT = 32'h10;
  // 4 periods of 10 beats with 5 table reads each
  localparam int B_BDL = 4;
  localparam int B_BLN = 9;
  localparam int B_BNM = 3;
  // beats per test
  localparam int N_PER   = 64;
  localparam int N_BURST = (B_BLN + 1) * (B_BNM + 1);
  localparam int N_STOP  = 20;
  // x4 for back-pressure plus a margin for the table fill and readback
  localparam int LIMIT = 4 * (N_PER + 2 * N_BURST + N_STOP) + 4000;

  logic        sto;
  logic        ctl_rst;
  logic        trg;
  reg_addr_t   axil_awaddr;
  logic        axil_awvalid;
  logic        axil_awready;
  logic [31:0] axil_wdata;
  logic [3:0]  axil_wstrb;
  logic        axil_wvalid;
  logic        axil_wready;
  logic [1:0]  axil_bresp;
  logic        axil_bvalid;
  logic        axil_bready;
  reg_addr_t   axil_araddr;
  logic        axil_arvalid;
  logic        axil_arready;
  logic [31:0] axil_rdata;
  logic [1:0]  axil_rresp;
  logic        axil_rvalid;
  logic        axil_rready;
  sample_t     out_tdata;
  logic        out_tvalid;
  logic        out_tlast;
  logic        out_tready;

  int          cyc;
  int          acc_cyc;
  int          first_cyc;
  int          last_cyc;
  int          n_errs;
  int          n_tests;
  int          n_clean;
  logic [16:0] lfsr_q;
  // model copies of table and settings
  sample_t     tab_img [0:TAB_N-1];
  int          c_siz;
  int          c_stp;
  int          c_off;
  int          c_bdl;
  int          c_bln;
  int          c_bnm;
  // captured, expected and test 3 streams
  sample_t     cap_data[$];
  logic        cap_last[$];
  sample_t     exp_data[$];
  logic        exp_last[$];
  sample_t     t3_data[$];
  logic        t3_last[$];

  asg_top DUT (.*);

  bind asg_top asg_props u_props (
    .sto(sto), .ctl_rst(ctl_rst),
    .out_tdata(out_tdata), .out_tvalid(out_tvalid), .out_tlast(out_tlast),
    .out_tready(out_tready), .stall(stall), .running(running),
    .axil_bvalid(axil_bvalid), .axil_bready(axil_bready),
    .axil_rvalid(axil_rvalid), .axil_rready(axil_rready)
  );

  always #2 sto = ~sto;

  // cycle count and run limit
  always @(posedge sto) begin
    cyc <= cyc + 1;
    if (cyc == LIMIT) begin
      $display("Error: timeout, no finish after %0d cycles", cyc);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // LFSR with taps at bits 17 and 14
  //////////////////////////////////////////////////

  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[16] ^ lfsr_q[13];
    lfsr_q = {lfsr_q[15:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  //////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////

  task automatic bad_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_errs++;
    $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
  endtask

  task automatic bad_event(input string what);
    n_errs++;
    $display("error: %s", what);
  endtask

  task automatic finish_test(input string name, input int e0);
    n_tests++;
    if (n_errs == e0) n_clean++;
    $display("test %0d %s: %s, %0d errors", n_tests, name, (n_errs == e0) ? "ok" : "bad",
             n_errs - e0);
  endtask

  //////////////////////////////////////////////////
  // bus and stream tasks
  //////////////////////////////////////////////////

  task automatic axil_write(input reg_addr_t addr, input logic [31:0] data);
    axil_awaddr  <= addr;
    axil_awvalid <= 1'b1;
    axil_wdata   <= data;
    axil_wvalid  <= 1'b1;
    do @(posedge sto); while (!axil_awready);
    // register update lands on this edge
    acc_cyc = cyc;
    if (!axil_wready) bad_event("wready stayed low while awready accepted the write");
    axil_awvalid <= 1'b0;
    axil_wvalid  <= 1'b0;
    do @(posedge sto); while (!axil_bvalid);
    if (axil_bresp !== 2'b00) bad_value("axil_bresp", 32'(axil_bresp), 32'h0);
    // response taken one cycle late
    axil_bready <= 1'b1;
    @(posedge sto);
    axil_bready <= 1'b0;
  endtask

  task automatic axil_read(input reg_addr_t addr, output logic [31:0] data);
    axil_araddr  <= addr;
    axil_arvalid <= 1'b1;
    do @(posedge sto); while (!axil_arready);
    axil_arvalid <= 1'b0;
    do @(posedge sto); while (!axil_rvalid);
    data = axil_rdata;
    if (axil_rresp !== 2'b00) bad_value("axil_rresp", 32'(axil_rresp), 32'h0);
    axil_rready <= 1'b1;
    @(posedge sto);
    axil_rready <= 1'b0;
  endtask

  task automatic set_phase(input int siz, input int stp, input int off);
    c_siz = siz;
    c_stp = stp;
    c_off = off;
    axil_write(ADDR_SIZ, siz);
    axil_write(ADDR_STP, stp);
    axil_write(ADDR_OFF, off);
  endtask

  task automatic set_burst(input int bdl, input int bln, input int bnm);
    c_bdl = bdl;
    c_bln = bln;
    c_bnm = bnm;
    axil_write(ADDR_BDL, bdl);
    axil_write(ADDR_BLN, bln);
    axil_write(ADDR_BNM, bnm);
  endtask

  task automatic pulse_trg();
    trg <= 1'b1;
    @(posedge sto);
    trg <= 1'b0;
  endtask

  // appends n beats while bp drives out_tready from the LFSR
  task automatic capture(input int n, input bit bp);
    int got;
    got = 0;
    while (got < n) begin
      @(posedge sto);
      if (out_tvalid && out_tready) begin
        if (cap_data.size() == 0) first_cyc = cyc;
        last_cyc = cyc;
        cap_data.push_back(out_tdata);
        cap_last.push_back(out_tlast);
        got++;
      end
      if (bp) out_tready <= lfsr_step();
    end
    out_tready <= 1'b1;
  endtask

  task automatic count_beats(input int cycles, output int seen);
    seen = 0;
    repeat (cycles) begin
      @(posedge sto);
      if (out_tvalid) seen++;
    end
  endtask

  // clear run enable and let the pipeline drain
  task automatic stop_run();
    axil_write(ADDR_CTRL, 32'h0);
    repeat (8) @(posedge sto);
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // pointer steps by stp+1 and wraps at siz+1 while bursts rewind to off
  task automatic predict(input bit burst, input int n);
    int      ptr;
    int      k;
    int      per;
    sample_t held;
    exp_data.delete();
    exp_last.delete();
    ptr  = c_off;
    k    = 0;
    per  = 0;
    held = '0;
    for (int i = 0; i < n; i++) begin
      // table read or a repeat of the held value
      if (!burst || k <= c_bdl) begin
        held = tab_img[(ptr >> `ASG_FW) % TAB_N];
        ptr  = ptr + c_stp + 1;
        if (ptr - (c_siz + 1) >= 0) ptr = ptr - (c_siz + 1);
      end
      exp_data.push_back(held);
      exp_last.push_back(burst && k == c_bln && per == c_bnm);
      if (burst && k == c_bln) begin
        k   = 0;
        ptr = c_off;
        per++;
      end else begin
        k++;
      end
    end
  endtask

  task automatic compare_stream();
    if (cap_data.size() != exp_data.size()) begin
      bad_event($sformatf("captured %0d beats, expected %0d", cap_data.size(),
                          exp_data.size()));
    end
    for (int i = 0; i < cap_data.size() && i < exp_data.size(); i++) begin
      if (cap_data[i] !== exp_data[i]) begin
        bad_value($sformatf("out_tdata beat %0d", i), 32'(cap_data[i]), 32'(exp_data[i]));
      end
      if (cap_last[i] !== exp_last[i]) begin
        bad_value($sformatf("out_tlast beat %0d", i), 32'(cap_last[i]), 32'(exp_last[i]));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_table();
    logic [31:0] rd;
    int          e0;
    e0 = n_errs;
    for (int i = 0; i < TAB_N; i++) begin
      tab_img[i] = sample_t'(rand_bits(`ASG_DW));
      axil_write(reg_addr_t'(TAB_BASE + 4 * i), 32'(tab_img[i]));
    end
    for (int i = 0; i < TAB_N; i++) begin
      axil_read(reg_addr_t'(TAB_BASE + 4 * i), rd);
      if (rd !== 32'(tab_img[i])) bad_value($sformatf("axil_rdata table[%0d]", i), rd,
                                            32'(tab_img[i]));
    end
    // 40 entries with step 2.75 and offset 17.5
    set_phase('h27FF, 'h02BF, 'h1180);
    axil_read(ADDR_SIZ, rd);
    if (rd !== 32'(c_siz)) bad_value("axil_rdata siz", rd, c_siz);
    axil_read(ADDR_STP, rd);
    if (rd !== 32'(c_stp)) bad_value("axil_rdata stp", rd, c_stp);
    axil_read(ADDR_OFF, rd);
    if (rd !== 32'(c_off)) bad_value("axil_rdata off", rd, c_off);
    finish_test("table and settings readback", e0);
  endtask

  task automatic test_periodic();
    int e0;
    e0 = n_errs;
    cap_data.delete();
    cap_last.delete();
    axil_write(ADDR_CTRL, C_RUN | C_SWT);
    capture(N_PER, 1'b0);
    // sw_trg high in cycle 0 gives tvalid in cycle 3 sampled at its closing edge
    if (first_cyc != acc_cyc + 4) begin
      bad_event($sformatf("first beat at cycle %0d, expected %0d", first_cyc, acc_cyc + 4));
    end
    if (last_cyc - first_cyc != N_PER - 1) bad_event("beats not back to back");
    predict(1'b0, N_PER);
    compare_stream();
    stop_run();
    finish_test("periodic playback", e0);
  endtask

  task automatic test_burst(input bit bp);
    int e0;
    int seen;
    e0 = n_errs;
    cap_data.delete();
    cap_last.delete();
    set_burst(B_BDL, B_BLN, B_BNM);
    axil_write(ADDR_CTRL, C_RUN | C_BST | C_EXT);
    pulse_trg();
    capture(N_BURST, bp);
    if (bp) begin
      exp_data = t3_data;
      exp_last = t3_last;
    end else begin
      predict(1'b1, N_BURST);
    end
    compare_stream();
    // finite burst parks in DONE
    count_beats(10, seen);
    if (seen != 0) bad_event("beats after the final burst sample");
    if (!bp) begin
      t3_data = cap_data;
      t3_last = cap_last;
    end
    stop_run();
    finish_test(bp ? "burst with back-pressure" : "burst playback", e0);
  endtask

  task automatic test_stop();
    logic [31:0] rd;
    int          e0;
    int          seen;
    e0 = n_errs;
    set_phase('h27FF, 'h02BF, 'h1180);
    // external trigger masked
    axil_write(ADDR_CTRL, C_RUN);
    pulse_trg();
    count_beats(20, seen);
    if (seen != 0) bad_event("beat appeared with the external trigger disabled");
    axil_read(ADDR_STATUS, rd);
    if (rd !== 32'h0) bad_value("axil_rdata status", rd, 32'h0);
    cap_data.delete();
    cap_last.delete();
    axil_write(ADDR_CTRL, C_RUN | C_SWT | C_EXT);
    capture(N_STOP / 2, 1'b0);
    // trigger mid-run must not rewind the pointer
    trg <= 1'b1;
    capture(1, 1'b0);
    trg <= 1'b0;
    capture(N_STOP / 2 - 1, 1'b0);
    predict(1'b0, N_STOP);
    compare_stream();
    axil_write(ADDR_CTRL, 32'h0);
    repeat (4) @(posedge sto);
    count_beats(20, seen);
    if (seen != 0) bad_event("stream restarted after run enable was cleared");
    axil_read(ADDR_STATUS, rd);
    if (rd !== 32'h0) bad_value("axil_rdata status", rd, 32'h0);
    finish_test("trigger mask and stop", e0);
  endtask

  initial begin
    sto          = 1'b0;
    ctl_rst      = 1'b1;
    trg          = 1'b0;
    axil_awaddr  = '0;
    axil_awvalid = 1'b0;
    axil_wdata   = '0;
    axil_wstrb   = 4'hF;
    axil_wvalid  = 1'b0;
    axil_bready  = 1'b0;
    axil_araddr  = '0;
    axil_arvalid = 1'b0;
    axil_rready  = 1'b0;
    out_tready   = 1'b1;
    cyc          = 0;
    n_errs       = 0;
    n_tests      = 0;
    n_clean      = 0;
    lfsr_q       = 17'd90579;
    repeat (8) @(posedge sto);
    ctl_rst <= 1'b0;
    @(posedge sto);
    test_table();
    test_periodic();
    test_burst(1'b0);
    test_burst(1'b1);
    test_stop();
    if (DUT.u_props.fail_cnt != 0) bad_event("concurrent assertions failed");
    $display("summary: %0d tests, %0d clean, %0d errors", n_tests, n_clean, n_errs);
    if (n_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
